// ==== verilog/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// ******************************
	// Geometry and address split
	// ******************************

	// Two ways of eight sets, 16-byte lines.
	localparam int NUM_SETS    = 8;
	localparam int OFFSET_BITS = 4;
	localparam int INDEX_BITS  = 3;
	localparam int TAG_BITS    = 9;

	// ******************************
	// Data types
	// ******************************

	typedef logic [15:0] cpu_addr_t;
	typedef logic [15:0] cpu_word_t;
	typedef logic [1:0]  byte_sel_t;
	typedef logic [127:0] line_t;

	// Line address is the CPU address without its byte offset.
	typedef logic [TAG_BITS+INDEX_BITS-1:0] line_addr_t;

	typedef logic [TAG_BITS-1:0]    tag_t;
	typedef logic [INDEX_BITS-1:0]  set_idx_t;
	typedef logic [OFFSET_BITS-2:0] word_off_t;

	typedef logic [15:0] count_t;

	// Memory address source.
	typedef logic [1:0] adr_src_t;

	localparam adr_src_t ADR_REQ      = 2'd0;
	localparam adr_src_t ADR_VICTIM   = 2'd1;
	localparam adr_src_t ADR_PREFETCH = 2'd2;

	// ******************************
	// Controller states
	// ******************************

	typedef enum logic [2:0] {
		IDLE,
		COMPARE,
		WRITEBACK,
		FILL,
		PF_CHECK,
		PF_WRITEBACK,
		PF_FILL
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/cache_ctrl_if.sv ====
`default_nettype none

interface cache_ctrl_if;

	// Controller to datapath.
	logic                 req_load;
	logic                 adr_load;
	logic                 way_fill;
	logic                 line_write;
	logic                 word_write;
	logic                 tag_write;
	logic                 valid_set;
	logic                 dirty_set;
	logic                 dirty_clear;
	logic                 lru_update;
	cache_pkg::adr_src_t  adr_src;
	logic                 prefetch_sel;

	// Datapath to controller.
	logic                 hit0;
	logic                 hit1;
	logic                 victim_way;
	logic                 victim_dirty;

	modport ctrl (
		output req_load, adr_load, way_fill, line_write, word_write, tag_write,
		output valid_set, dirty_set, dirty_clear, lru_update, adr_src, prefetch_sel,
		input  hit0, hit1, victim_way, victim_dirty
	);

	modport dp (
		input  req_load, adr_load, way_fill, line_write, word_write, tag_write,
		input  valid_set, dirty_set, dirty_clear, lru_update, adr_src, prefetch_sel,
		output hit0, hit1, victim_way, victim_dirty
	);

endinterface

`default_nettype wire

// ==== verilog/cache_datapath.sv ====
`default_nettype none

module cache_datapath (
	input  logic                   clk,
	input  logic                   arst_n,
	cache_ctrl_if.dp               ctl,
	input  cache_pkg::cpu_addr_t   cpu_adr,
	input  cache_pkg::byte_sel_t   cpu_sel,
	input  cache_pkg::cpu_word_t   cpu_dat_w,
	output cache_pkg::cpu_word_t   cpu_dat_r,
	input  cache_pkg::line_t       mem_dat_r,
	output cache_pkg::line_t       mem_dat_w,
	output cache_pkg::line_addr_t  mem_adr
);

	cache_pkg::cpu_addr_t  req_q;
	cache_pkg::line_addr_t req_line;
	cache_pkg::line_addr_t pf_line;
	cache_pkg::line_addr_t cur_line;
	cache_pkg::line_addr_t adr_nxt;
	cache_pkg::tag_t       cur_tag;
	cache_pkg::set_idx_t   cur_idx;
	cache_pkg::word_off_t  req_off;
	cache_pkg::line_t      way_line;
	cache_pkg::line_t      hit_line;
	cache_pkg::line_t      merge_line;
	logic                  victim;

	// ******************************
	// Arrays
	// ******************************

	cache_pkg::line_t data_q [2][cache_pkg::NUM_SETS];
	cache_pkg::tag_t  tag_q  [2][cache_pkg::NUM_SETS];

	logic [cache_pkg::NUM_SETS-1:0] valid_q [2];
	logic [cache_pkg::NUM_SETS-1:0] dirty_q [2];
	logic [cache_pkg::NUM_SETS-1:0] lru_q;

	// Request is held here for the whole miss and prefetch sequence.
	always_ff @(posedge clk) begin
		if (ctl.req_load) begin
			req_q <= cpu_adr;
		end
	end

	assign req_line = req_q[$bits(cache_pkg::cpu_addr_t)-1:cache_pkg::OFFSET_BITS];
	assign req_off  = req_q[cache_pkg::OFFSET_BITS-1:1];

	// Next line, index overflow carries into the tag.
	assign pf_line  = req_line + 1'b1;
	assign cur_line = ctl.prefetch_sel ? pf_line : req_line;
	assign cur_idx  = cur_line[cache_pkg::INDEX_BITS-1:0];
	assign cur_tag  = cur_line[cache_pkg::INDEX_BITS +: cache_pkg::TAG_BITS];

	// ******************************
	// Lookup
	// ******************************

	assign ctl.hit0 = valid_q[0][cur_idx] && (tag_q[0][cur_idx] == cur_tag);
	assign ctl.hit1 = valid_q[1][cur_idx] && (tag_q[1][cur_idx] == cur_tag);

	// Empty way first, then LRU.
	assign victim = !valid_q[0][cur_idx] ? 1'b0 :
	                !valid_q[1][cur_idx] ? 1'b1 : lru_q[cur_idx];

	assign ctl.victim_way   = victim;
	assign ctl.victim_dirty = valid_q[victim][cur_idx] && dirty_q[victim][cur_idx];

	assign hit_line = data_q[ctl.hit1][cur_idx];
	assign way_line = data_q[ctl.way_fill][cur_idx];

	// Byte-enabled write into one word of the line.
	always_comb begin
		merge_line = way_line;
		if (cpu_sel[0]) begin
			merge_line[{req_off, 4'd0} +: 8] = cpu_dat_w[7:0];
		end
		if (cpu_sel[1]) begin
			merge_line[{req_off, 4'd8} +: 8] = cpu_dat_w[15:8];
		end
	end

	always_ff @(posedge clk) begin
		if (ctl.line_write) begin
			data_q[ctl.way_fill][cur_idx] <= mem_dat_r;
		end else if (ctl.word_write) begin
			data_q[ctl.way_fill][cur_idx] <= merge_line;
		end
		if (ctl.tag_write) begin
			tag_q[ctl.way_fill][cur_idx] <= cur_tag;
		end
		cpu_dat_r <= hit_line[{req_off, 4'd0} +: 16];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '{default: '0};
			dirty_q <= '{default: '0};
			lru_q   <= '0;
		end else begin
			if (ctl.valid_set) begin
				valid_q[ctl.way_fill][cur_idx] <= 1'b1;
			end
			if (ctl.dirty_set) begin
				dirty_q[ctl.way_fill][cur_idx] <= 1'b1;
			end else if (ctl.dirty_clear) begin
				dirty_q[ctl.way_fill][cur_idx] <= 1'b0;
			end
			// The other way becomes least recent.
			if (ctl.lru_update) begin
				lru_q[cur_idx] <= ~ctl.way_fill;
			end
		end
	end

	// ******************************
	// Memory side
	// ******************************

	assign mem_dat_w = data_q[victim][cur_idx];

	always_comb begin
		case (ctl.adr_src)
			cache_pkg::ADR_VICTIM:   adr_nxt = {tag_q[victim][cur_idx], cur_idx};
			cache_pkg::ADR_PREFETCH: adr_nxt = pf_line;
			default:                 adr_nxt = req_line;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ctl.adr_load) begin
			mem_adr <= adr_nxt;
		end
	end

	// A tag lives in one way only.
	one_hit: assert property (@(posedge clk) disable iff (!arst_n)
		!(ctl.hit0 && ctl.hit1));

endmodule

`default_nettype wire

// ==== verilog/cache_control.sv ====
`default_nettype none

module cache_control (
	input  logic        clk,
	input  logic        arst_n,
	cache_ctrl_if.ctrl  ctl,
	input  logic        cpu_cyc,
	input  logic        cpu_stb,
	input  logic        cpu_we,
	input  logic        mem_ack,
	output logic        cpu_ack,
	output logic        cpu_rty,
	output logic        mem_cyc,
	output logic        mem_stb,
	output logic        mem_we,
	output logic        hit_pulse,
	output logic        miss_pulse
);

	cache_pkg::ctrl_state_t state, state_nxt;

	logic req;
	logic hit;
	logic miss_q;
	logic mem_state;
	logic mem_start;
	logic mem_done;

	assign req     = cpu_cyc && cpu_stb;
	assign hit     = ctl.hit0 || ctl.hit1;
	assign cpu_rty = req && !cpu_ack;
	assign mem_stb = mem_cyc;

	assign mem_state = state inside {cache_pkg::WRITEBACK, cache_pkg::FILL,
	                                 cache_pkg::PF_WRITEBACK, cache_pkg::PF_FILL};
	// Each memory state opens its own bus cycle.
	assign mem_start = mem_state && !mem_cyc;
	assign mem_done  = mem_cyc && mem_ack;

	assign hit_pulse  = (state == cache_pkg::COMPARE) && hit && !miss_q;
	assign miss_pulse = (state == cache_pkg::COMPARE) && !hit && !miss_q;

	// ******************************
	// Next state
	// ******************************

	always_comb begin
		state_nxt = state;
		case (state)
			cache_pkg::IDLE: begin
				if (req && !cpu_ack) begin
					state_nxt = cache_pkg::COMPARE;
				end
			end
			cache_pkg::COMPARE: begin
				if (hit) begin
					state_nxt = (miss_q && !cpu_we) ? cache_pkg::PF_CHECK : cache_pkg::IDLE;
				end else begin
					state_nxt = ctl.victim_dirty ? cache_pkg::WRITEBACK : cache_pkg::FILL;
				end
			end
			cache_pkg::WRITEBACK: begin
				if (mem_done) begin
					state_nxt = cache_pkg::FILL;
				end
			end
			cache_pkg::FILL: begin
				if (mem_done) begin
					state_nxt = cache_pkg::COMPARE;
				end
			end
			cache_pkg::PF_CHECK: begin
				if (hit) begin
					state_nxt = cache_pkg::IDLE;
				end else begin
					state_nxt = ctl.victim_dirty ? cache_pkg::PF_WRITEBACK : cache_pkg::PF_FILL;
				end
			end
			cache_pkg::PF_WRITEBACK: begin
				if (mem_done) begin
					state_nxt = cache_pkg::PF_FILL;
				end
			end
			cache_pkg::PF_FILL: begin
				if (mem_done) begin
					state_nxt = cache_pkg::IDLE;
				end
			end
			default: state_nxt = cache_pkg::IDLE;
		endcase
	end

	// ******************************
	// Datapath control
	// ******************************

	always_comb begin
		ctl.req_load     = (state == cache_pkg::IDLE) && req && !cpu_ack;
		ctl.adr_load     = mem_start;
		ctl.way_fill     = ctl.victim_way;
		ctl.line_write   = 1'b0;
		ctl.word_write   = 1'b0;
		ctl.tag_write    = 1'b0;
		ctl.valid_set    = 1'b0;
		ctl.dirty_set    = 1'b0;
		ctl.dirty_clear  = 1'b0;
		ctl.lru_update   = 1'b0;
		ctl.adr_src      = cache_pkg::ADR_REQ;
		ctl.prefetch_sel = state inside {cache_pkg::PF_CHECK, cache_pkg::PF_WRITEBACK,
		                                 cache_pkg::PF_FILL};
		case (state)
			cache_pkg::COMPARE: begin
				if (hit) begin
					ctl.way_fill   = ctl.hit1;
					ctl.lru_update = 1'b1;
					ctl.word_write = cpu_we;
					ctl.dirty_set  = cpu_we;
				end
			end
			cache_pkg::WRITEBACK, cache_pkg::PF_WRITEBACK: begin
				ctl.adr_src = cache_pkg::ADR_VICTIM;
			end
			cache_pkg::FILL, cache_pkg::PF_FILL: begin
				if (state == cache_pkg::PF_FILL) begin
					ctl.adr_src = cache_pkg::ADR_PREFETCH;
				end
				ctl.line_write  = mem_done;
				ctl.tag_write   = mem_done;
				ctl.valid_set   = mem_done;
				ctl.dirty_clear = mem_done;
				ctl.lru_update  = mem_done;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= cache_pkg::IDLE;
			miss_q  <= 1'b0;
			cpu_ack <= 1'b0;
			mem_cyc <= 1'b0;
			mem_we  <= 1'b0;
		end else begin
			state   <= state_nxt;
			cpu_ack <= (state == cache_pkg::COMPARE) && hit;
			if (state == cache_pkg::COMPARE) begin
				miss_q <= !hit;
			end
			if (mem_start) begin
				mem_cyc <= 1'b1;
				mem_we  <= state inside {cache_pkg::WRITEBACK, cache_pkg::PF_WRITEBACK};
			end else if (mem_done) begin
				mem_cyc <= 1'b0;
				mem_we  <= 1'b0;
			end
		end
	end

	// ******************************
	// Checks
	// ******************************

	// Write-back is the only bus write.
	we_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		mem_we |-> (mem_cyc && (state == cache_pkg::WRITEBACK ||
			state == cache_pkg::PF_WRITEBACK)));

	ack_single: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_ack |=> !cpu_ack);

	// Bus cycle, and so the registered address, holds until the ack.
	adr_steady: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_cyc && !mem_ack) |=> (mem_cyc && $stable(mem_we) && $stable(ctl.adr_src)));

endmodule

`default_nettype wire

// ==== verilog/cache_stats.sv ====
`default_nettype none

module cache_stats (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               hit_pulse,
	input  logic               miss_pulse,
	input  logic               hit_clear,
	input  logic               miss_clear,
	output cache_pkg::count_t  hit_cnt,
	output cache_pkg::count_t  miss_cnt
);

	logic [1:0] inc;
	logic [1:0] clr;

	assign inc = {miss_pulse, hit_pulse};
	assign clr = {miss_clear, hit_clear};

	// Wrapping counters, clear wins over increment.
	for (genvar i = 0; i < 2; i++) begin : g_cnt
		cache_pkg::count_t cnt_q;

		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				cnt_q <= '0;
			end else if (clr[i]) begin
				cnt_q <= '0;
			end else if (inc[i]) begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	assign hit_cnt  = g_cnt[0].cnt_q;
	assign miss_cnt = g_cnt[1].cnt_q;

endmodule

`default_nettype wire

// ==== verilog/cache_prefetch.sv ====
`default_nettype none

module cache_prefetch (
	input  logic                   clk,
	input  logic                   arst_n,
	// CPU port.
	input  logic                   cpu_cyc,
	input  logic                   cpu_stb,
	input  logic                   cpu_we,
	input  cache_pkg::cpu_addr_t   cpu_adr,
	input  cache_pkg::byte_sel_t   cpu_sel,
	input  cache_pkg::cpu_word_t   cpu_dat_w,
	output cache_pkg::cpu_word_t   cpu_dat_r,
	output logic                   cpu_ack,
	output logic                   cpu_rty,
	// Memory port, one line per transfer.
	output logic                   mem_cyc,
	output logic                   mem_stb,
	output logic                   mem_we,
	output cache_pkg::line_addr_t  mem_adr,
	output cache_pkg::line_t       mem_dat_w,
	input  cache_pkg::line_t       mem_dat_r,
	input  logic                   mem_ack,
	// Statistics.
	input  logic                   hit_clear,
	input  logic                   miss_clear,
	output cache_pkg::count_t      hit_cnt,
	output cache_pkg::count_t      miss_cnt
);

	logic hit_pulse;
	logic miss_pulse;

	cache_ctrl_if ctl_if ();

	cache_datapath cache_datapath_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.ctl       (ctl_if.dp),
		.cpu_adr   (cpu_adr),
		.cpu_sel   (cpu_sel),
		.cpu_dat_w (cpu_dat_w),
		.cpu_dat_r (cpu_dat_r),
		.mem_dat_r (mem_dat_r),
		.mem_dat_w (mem_dat_w),
		.mem_adr   (mem_adr)
	);

	cache_control cache_control_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.ctl        (ctl_if.ctrl),
		.cpu_cyc    (cpu_cyc),
		.cpu_stb    (cpu_stb),
		.cpu_we     (cpu_we),
		.mem_ack    (mem_ack),
		.cpu_ack    (cpu_ack),
		.cpu_rty    (cpu_rty),
		.mem_cyc    (mem_cyc),
		.mem_stb    (mem_stb),
		.mem_we     (mem_we),
		.hit_pulse  (hit_pulse),
		.miss_pulse (miss_pulse)
	);

	cache_stats cache_stats_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.hit_pulse  (hit_pulse),
		.miss_pulse (miss_pulse),
		.hit_clear  (hit_clear),
		.miss_clear (miss_clear),
		.hit_cnt    (hit_cnt),
		.miss_cnt   (miss_cnt)
	);

endmodule

`default_nettype wire

// ==== test/tb_mem_model.sv ====
`default_nettype none

module tb_mem_model (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   mem_cyc,
	input  logic                   mem_stb,
	input  logic                   mem_we,
	input  cache_pkg::line_addr_t  mem_adr,
	input  cache_pkg::line_t       mem_dat_w,
	output cache_pkg::line_t       mem_dat_r,
	output logic                   mem_ack
);

	localparam int          NUM_LINES = 4096;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	cache_pkg::line_t lines [NUM_LINES];

	logic [31:0] lfsr;
	logic [31:0] lfsr_one;
	logic [31:0] lfsr_two;
	logic        busy;
	logic [1:0]  wait_cnt;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// Word at word address a starts as a ^ 16'h5a5a.
	function automatic cache_pkg::line_t reset_line(input cache_pkg::line_addr_t adr);
		cache_pkg::line_t l;
		for (int w = 0; w < 8; w++) begin
			l[16*w +: 16] = {1'b0, adr, 3'(w)} ^ 16'h5a5a;
		end
		return l;
	endfunction

	initial begin
		for (int a = 0; a < NUM_LINES; a++) begin
			lines[a] = reset_line(12'(a));
		end
	end

	assign lfsr_one = lfsr_step(lfsr);
	assign lfsr_two = lfsr_step(lfsr_one);

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr      <= 32'hace1;
			busy      <= 1'b0;
			wait_cnt  <= 2'd0;
			mem_ack   <= 1'b0;
			mem_dat_r <= '0;
		end else if (mem_ack) begin
			mem_ack <= 1'b0;
			busy    <= 1'b0;
		end else if (mem_cyc && mem_stb && !busy) begin
			// Two bits per access, ack follows 1 to 4 cycles later.
			busy     <= 1'b1;
			wait_cnt <= {lfsr_one[0], lfsr[0]};
			lfsr     <= lfsr_two;
		end else if (busy) begin
			if (wait_cnt == 2'd0) begin
				mem_ack <= 1'b1;
				if (mem_we) begin
					lines[mem_adr] = mem_dat_w;
				end else begin
					mem_dat_r <= lines[mem_adr];
				end
			end else begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_cache_prefetch.sv ====
`default_nettype none

module tb_cache_prefetch;

	localparam int CYCLES_PER_LINE = 60;

	logic                  clk;
	logic                  arst_n;
	logic                  cpu_cyc;
	logic                  cpu_stb;
	logic                  cpu_we;
	cache_pkg::cpu_addr_t  cpu_adr;
	cache_pkg::byte_sel_t  cpu_sel;
	cache_pkg::cpu_word_t  cpu_dat_w;
	cache_pkg::cpu_word_t  cpu_dat_r;
	logic                  cpu_ack;
	logic                  cpu_rty;
	logic                  mem_cyc;
	logic                  mem_stb;
	logic                  mem_we;
	cache_pkg::line_addr_t mem_adr;
	cache_pkg::line_t      mem_dat_w;
	cache_pkg::line_t      mem_dat_r;
	logic                  mem_ack;
	logic                  hit_clear;
	logic                  miss_clear;
	cache_pkg::count_t     hit_cnt;
	cache_pkg::count_t     miss_cnt;

	// One entry per stim line.
	logic [63:0]          op_q     [$];
	cache_pkg::cpu_addr_t adr_q    [$];
	cache_pkg::byte_sel_t sel_q    [$];
	cache_pkg::cpu_word_t wdat_q   [$];
	cache_pkg::cpu_word_t rdat_q   [$];
	cache_pkg::count_t    hits_q   [$];
	cache_pkg::count_t    misses_q [$];

	int errors;
	int checks;
	int cycle_cnt;
	int limit_cycles;

	cache_prefetch cache_prefetch_inst (.*);

	tb_mem_model mem_model_inst (.*);

	always #4 clk = ~clk;

	// Hang guard, limit is set once the stim file is loaded.
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (limit_cycles != 0 && cycle_cnt >= limit_cycles) begin
			$display("Timeout after %0d cycles, the cache never finished the sequence.",
				cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ******************************
	// Stim file
	// ******************************

	function automatic bit load_stim();
		int          fd;
		int          n;
		bit          ok;
		string       line;
		logic [63:0] op;
		logic [15:0] adr;
		logic [15:0] sel;
		logic [15:0] wdat;
		logic [15:0] rdat;
		logic [15:0] hits;
		logic [15:0] misses;
		ok = 1'b1;
		fd = $fopen("test/cache_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open test/cache_stim.txt for reading.");
			return 1'b0;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %h %h %h %h %h %h", op, adr, sel, wdat, rdat, hits, misses);
				if (n != 7) begin
					$display("Stim line could not be parsed: %s", line);
					ok = 1'b0;
				end else begin
					op_q.push_back(op);
					adr_q.push_back(adr);
					sel_q.push_back(sel[1:0]);
					wdat_q.push_back(wdat);
					rdat_q.push_back(rdat);
					hits_q.push_back(hits);
					misses_q.push_back(misses);
				end
			end
		end
		$fclose(fd);
		return ok && (op_q.size() > 0);
	endfunction

	// ******************************
	// Bus operations
	// ******************************

	task automatic cpu_request(input logic we, input cache_pkg::cpu_addr_t adr,
			input cache_pkg::byte_sel_t sel, input cache_pkg::cpu_word_t wdat,
			output cache_pkg::cpu_word_t rdat);
		@(posedge clk);
		#1;
		cpu_cyc   = 1'b1;
		cpu_stb   = 1'b1;
		cpu_we    = we;
		cpu_adr   = adr;
		cpu_sel   = sel;
		cpu_dat_w = wdat;
		@(negedge clk);
		// Retry must cover every wait state.
		while (!cpu_ack) begin
			checks++;
			if (!cpu_rty) begin
				errors++;
				$display("[ERROR] %0t: cpu_rty low while request %h waits", $time, adr);
			end
			@(negedge clk);
		end
		checks++;
		if (cpu_rty) begin
			errors++;
			$display("[ERROR] %0t: cpu_rty high during the ack of request %h", $time, adr);
		end
		rdat = cpu_dat_r;
		@(posedge clk);
		#1;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we  = 1'b0;
	endtask

	task automatic pulse_clear(input cache_pkg::byte_sel_t which);
		@(posedge clk);
		#1;
		hit_clear  = which[0];
		miss_clear = which[1];
		@(posedge clk);
		#1;
		hit_clear  = 1'b0;
		miss_clear = 1'b0;
	endtask

	task automatic check_counts(input cache_pkg::count_t hits, input cache_pkg::count_t misses);
		@(negedge clk);
		checks += 2;
		if (hit_cnt !== hits) begin
			errors++;
			$display("[ERROR] %0t: hit_cnt is %h, expected %h", $time, hit_cnt, hits);
		end
		if (miss_cnt !== misses) begin
			errors++;
			$display("[ERROR] %0t: miss_cnt is %h, expected %h", $time, miss_cnt, misses);
		end
	endtask

	task automatic play_op(input int i);
		cache_pkg::cpu_word_t rdat;
		case (op_q[i])
			"read": begin
				cpu_request(1'b0, adr_q[i], sel_q[i], wdat_q[i], rdat);
				checks++;
				if (rdat !== rdat_q[i]) begin
					errors++;
					$display("[ERROR] %0t: read of %h returned %h, expected %h",
						$time, adr_q[i], rdat, rdat_q[i]);
				end
			end
			"write": cpu_request(1'b1, adr_q[i], sel_q[i], wdat_q[i], rdat);
			"clear": pulse_clear(sel_q[i]);
			"check": check_counts(hits_q[i], misses_q[i]);
			default: begin
				errors++;
				$display("Unknown operation on stim entry %0d.", i + 1);
			end
		endcase
	endtask

	task automatic run_sequence();
		repeat (16) @(posedge clk);
		#1 arst_n = 1'b1;
		for (int i = 0; i < op_q.size(); i++) begin
			play_op(i);
		end
		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	initial begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		cpu_cyc      = 1'b0;
		cpu_stb      = 1'b0;
		cpu_we       = 1'b0;
		cpu_adr      = '0;
		cpu_sel      = '0;
		cpu_dat_w    = '0;
		hit_clear    = 1'b0;
		miss_clear   = 1'b0;
		errors       = 0;
		checks       = 0;
		cycle_cnt    = 0;
		limit_cycles = 0;
		if (!load_stim()) begin
			$display("No usable stim entries were read.");
			$display("TEST FAILED");
			$finish;
		end else begin
			limit_cycles = op_q.size() * CYCLES_PER_LINE;
			run_sequence();
		end
	end

endmodule

`default_nettype wire

// ==== test/cache_stim.txt ====
# op addr sel wdata rdata hits misses, all hex; rdata is compared on read only
# check compares hit and miss counts; clear uses sel bit 0 for hits, bit 1 for misses
read  0100 3 0000 5ada 0000 0000
read  0106 3 0000 5ad9 0000 0000
check 0000 0 0000 0000 0001 0001
read  0112 3 0000 5ad3 0000 0000
check 0000 0 0000 0000 0002 0001
write 0114 1 a1b2 0000 0000 0000
write 0116 2 c3d4 0000 0000 0000
write 0118 3 e5f6 0000 0000 0000
read  0114 3 0000 5ab2 0000 0000
read  0116 3 0000 c3d1 0000 0000
read  0118 3 0000 e5f6 0000 0000
check 0000 0 0000 0000 0008 0001
read  0290 3 0000 5b12 0000 0000
read  0490 3 0000 5812 0000 0000
read  0116 3 0000 c3d1 0000 0000
read  0114 3 0000 5ab2 0000 0000
read  0118 3 0000 e5f6 0000 0000
check 0000 0 0000 0000 000a 0004
clear 0000 1 0000 0000 0000 0000
check 0000 0 0000 0000 0000 0004
read  0100 3 0000 5ada 0000 0000
check 0000 0 0000 0000 0001 0004
clear 0000 2 0000 0000 0000 0000
check 0000 0 0000 0000 0001 0000
read  0800 3 0000 5e5a 0000 0000
read  0812 3 0000 5e53 0000 0000
check 0000 0 0000 0000 0002 0001
read  0f70 3 0000 5de2 0000 0000
write 0f82 3 1234 0000 0000 0000
read  0f82 3 0000 1234 0000 0000
check 0000 0 0000 0000 0004 0002

// ==== project.f ====
verilog/cache_pkg.sv
verilog/cache_ctrl_if.sv
verilog/cache_datapath.sv
verilog/cache_control.sv
verilog/cache_stats.sv
verilog/cache_prefetch.sv
test/tb_mem_model.sv
test/tb_cache_prefetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_cache_prefetch
RTL_TOP   ?= cache_prefetch
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(TB_TOP)

# The run passes only if the pass message appears as a line of its own.
run: build
	@out="$$($(OBJ_DIR)/$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
